// ==== rtl/nnPkg.sv ====
`default_nettype none

package nnPkg;

	// ******************************
	// datapath sizes
	// ******************************
	localparam int dataWidth = 8;
	localparam int neuronInputs = 15;
	localparam int neuronCount = 4;
	localparam int neuronIdxWidth = 2;
	localparam int biasWidth = 16;
	localparam int accWidth = 23;
	localparam int fracShift = 6;
	localparam logic [accWidth-1:0] satLimit = accWidth'(8192);
	localparam logic [dataWidth-1:0] satValue = dataWidth'(127);
	localparam logic [neuronIdxWidth-1:0] lastNeuron = neuronIdxWidth'(neuronCount - 1);

	// ******************************
	// register map
	// ******************************
	// all byte addresses, one 32 bit word per register
	localparam logic [11:0] ctrlAddr = 12'h000;
	localparam logic [11:0] statusAddr = 12'h004;
	localparam logic [11:0] inputBase = 12'h040;
	localparam logic [11:0] weightBase = 12'h100;
	localparam logic [11:0] resultBase = 12'h200;

	typedef struct packed {
		logic [11:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// slot 15 carries the bias, lower slots one weight each
	typedef struct packed {
		logic valid;
		logic [neuronIdxWidth-1:0] neuron;
		logic [3:0] slot;
		logic [biasWidth-1:0] data;
	} weightWrite;

	typedef struct packed {
		logic [neuronInputs-1:0][dataWidth-1:0] weights;
		logic [biasWidth-1:0] bias;
	} neuronParams;

	typedef struct packed {
		logic valid;
		logic [neuronIdxWidth-1:0] neuron;
	} dotIssue;

	typedef struct packed {
		logic valid;
		logic [neuronIdxWidth-1:0] neuron;
		logic [accWidth-1:0] sum;
	} dotResult;

	typedef struct packed {
		logic valid;
		logic [neuronIdxWidth-1:0] neuron;
		logic [dataWidth-1:0] value;
	} activation;

	typedef enum logic [1:0] {
		idle,
		issue,
		drain,
		finish
	} ctrlState;

endpackage

`default_nettype wire

// ==== rtl/apbRegs.sv ====
`default_nettype none

module apbRegs (
	input wire logic clk,
	input wire logic reset,
	input nnPkg::apbReq apbIn,
	output nnPkg::apbRsp apbOut,
	input wire logic busy,
	input wire logic done,
	input nnPkg::activation result,
	output nnPkg::weightWrite weightWr,
	output logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] inputVector,
	output logic start
);

	logic access;
	logic writeAccess;
	logic ctrlHit;
	logic statusHit;
	logic inputHit;
	logic weightHit;
	logic resultHit;
	logic mapped;
	logic lockedWrite;
	logic [3:0] inputIdx;
	logic [31:0] readData;
	logic [nnPkg::neuronCount-1:0][nnPkg::dataWidth-1:0] results;

	// ******************************
	// address decode
	// ******************************
	assign access = apbIn.psel && apbIn.penable;
	assign writeAccess = access && apbIn.pwrite;
	assign inputIdx = apbIn.paddr[5:2];

	assign ctrlHit = apbIn.paddr == nnPkg::ctrlAddr;
	assign statusHit = apbIn.paddr == nnPkg::statusAddr;
	// the last word of the input window has no input behind it
	assign inputHit = (apbIn.paddr[11:6] == nnPkg::inputBase[11:6])
		&& (inputIdx != 4'(nnPkg::neuronInputs));
	assign weightHit = apbIn.paddr[11:8] == nnPkg::weightBase[11:8];
	assign resultHit = apbIn.paddr[11:4] == nnPkg::resultBase[11:4];
	assign mapped = ctrlHit || statusHit || inputHit || weightHit || resultHit;

	// writes that would disturb a run in flight
	assign lockedWrite = inputHit || weightHit || (ctrlHit && apbIn.pwdata[0]);

	assign start = writeAccess && ctrlHit && apbIn.pwdata[0] && !busy;

	assign weightWr.valid = writeAccess && weightHit && !busy;
	assign weightWr.neuron = apbIn.paddr[7:6];
	assign weightWr.slot = apbIn.paddr[5:2];
	assign weightWr.data = apbIn.pwdata[nnPkg::biasWidth-1:0];

	always_ff @(posedge clk)
	begin
		if (writeAccess && inputHit && !busy)
			inputVector[inputIdx] <= apbIn.pwdata[nnPkg::dataWidth-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			results <= '0;
		else if (result.valid)
			results[result.neuron] <= result.value;
	end

	// ******************************
	// read path and response
	// ******************************
	always_comb
	begin
		readData = '0;
		if (statusHit)
		begin
			readData[0] = busy;
			readData[1] = done;
		end
		else if (inputHit)
			readData[nnPkg::dataWidth-1:0] = inputVector[inputIdx];
		else if (resultHit)
			readData[nnPkg::dataWidth-1:0] = results[apbIn.paddr[3:2]];
	end

	assign apbOut.prdata = readData;
	assign apbOut.pready = 1'b1;
	assign apbOut.pslverr = access && (!mapped || (apbIn.pwrite && busy && lockedWrite));

endmodule

`default_nettype wire

// ==== rtl/weightStore.sv ====
`default_nettype none

module weightStore (
	input wire logic clk,
	input wire logic reset,
	input nnPkg::weightWrite weightWr,
	input nnPkg::dotIssue issueIn,
	output nnPkg::dotIssue issueOut,
	output nnPkg::neuronParams params
);

	nnPkg::neuronParams store [nnPkg::neuronCount];

	always_ff @(posedge clk)
	begin
		if (weightWr.valid)
		begin
			if (weightWr.slot == 4'hF)
				store[weightWr.neuron].bias <= weightWr.data;
			else
				store[weightWr.neuron].weights[weightWr.slot] <=
					weightWr.data[nnPkg::dataWidth-1:0];
		end
	end

	// registered read, the tag follows one cycle later to stay aligned
	always_ff @(posedge clk)
	begin
		params <= store[issueIn.neuron];
		issueOut.neuron <= issueIn.neuron;
		if (reset)
			issueOut.valid <= 1'b0;
		else
			issueOut.valid <= issueIn.valid;
	end

	// host writes are refused while busy, so they never meet an issued neuron
	weightsStableDuringRun: assert property (
		@(posedge clk) disable iff (reset)
		weightWr.valid |-> !issueIn.valid
	);

endmodule

`default_nettype wire

// ==== rtl/neuronDot.sv ====
`default_nettype none

module neuronDot (
	input wire logic clk,
	input wire logic reset,
	input nnPkg::dotIssue issueIn,
	input nnPkg::neuronParams params,
	input wire logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] inputVector,
	output nnPkg::dotResult sum
);

	nnPkg::dotIssue capTag;
	nnPkg::neuronParams capParams;
	logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] capInputs;
	logic [nnPkg::accWidth-1:0] acc;

	// stage one holds inputs and parameters steady for the sum
	always_ff @(posedge clk)
	begin
		capInputs <= inputVector;
		capParams <= params;
		capTag.neuron <= issueIn.neuron;
		if (reset)
			capTag.valid <= 1'b0;
		else
			capTag.valid <= issueIn.valid;
	end

	// products are signed 8 x 8, widened to the accumulator by hand
	always_comb
	begin
		logic [2*nnPkg::dataWidth-1:0] prod;
		logic [nnPkg::dataWidth-1:0] a;
		logic [nnPkg::dataWidth-1:0] w;
		acc = {{(nnPkg::accWidth-nnPkg::biasWidth){capParams.bias[nnPkg::biasWidth-1]}},
			capParams.bias};
		for (int i = 0; i < nnPkg::neuronInputs; i++)
		begin
			a = capInputs[i];
			w = capParams.weights[i];
			prod = $signed({{nnPkg::dataWidth{a[nnPkg::dataWidth-1]}}, a})
				* $signed({{nnPkg::dataWidth{w[nnPkg::dataWidth-1]}}, w});
			acc = acc + {{(nnPkg::accWidth-2*nnPkg::dataWidth){prod[2*nnPkg::dataWidth-1]}},
				prod};
		end
	end

	always_ff @(posedge clk)
	begin
		sum.sum <= acc;
		sum.neuron <= capTag.neuron;
		if (reset)
			sum.valid <= 1'b0;
		else
			sum.valid <= capTag.valid;
	end

endmodule

`default_nettype wire

// ==== rtl/reluQuant.sv ====
`default_nettype none

module reluQuant (
	input wire logic clk,
	input wire logic reset,
	input nnPkg::dotResult sum,
	output nnPkg::activation result
);

	logic [nnPkg::dataWidth-1:0] value;

	// rounding can lift the top unsaturated value to 128
	always_comb
	begin
		if (sum.sum[nnPkg::accWidth-1])
			value = '0;
		else if (sum.sum >= nnPkg::satLimit)
			value = nnPkg::satValue;
		else
			value = sum.sum[nnPkg::fracShift +: nnPkg::dataWidth]
				+ {{(nnPkg::dataWidth-1){1'b0}}, sum.sum[nnPkg::fracShift-1]};
	end

	always_ff @(posedge clk)
	begin
		result.value <= value;
		result.neuron <= sum.neuron;
		if (reset)
			result.valid <= 1'b0;
		else
			result.valid <= sum.valid;
	end

	outputInRange: assert property (
		@(posedge clk) disable iff (reset)
		result.valid |-> result.value <= 8'd128
	);

endmodule

`default_nettype wire

// ==== rtl/layerCtrl.sv ====
`default_nettype none

module layerCtrl (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input nnPkg::activation result,
	output nnPkg::dotIssue issue,
	output logic busy,
	output logic done
);

	nnPkg::ctrlState state;
	logic [nnPkg::neuronIdxWidth-1:0] count;
	logic lastResult;

	assign lastResult = result.valid && (result.neuron == nnPkg::lastNeuron);

	// ******************************
	// run sequencing
	// ******************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::idle;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				nnPkg::issue:
				begin
					count <= count + 1'b1;
					if (count == nnPkg::lastNeuron)
						state <= nnPkg::drain;
				end
				nnPkg::drain:
				begin
					// done shows up together with busy dropping
					if (lastResult)
					begin
						state <= nnPkg::finish;
						done <= 1'b1;
					end
				end
				default:
				begin
					if (start)
					begin
						state <= nnPkg::issue;
						count <= '0;
						done <= 1'b0;
					end
					else
						state <= nnPkg::idle;
				end
			endcase
		end
	end

	// one neuron per cycle while issuing
	assign issue.valid = state == nnPkg::issue;
	assign issue.neuron = count;
	assign busy = (state == nnPkg::issue) || (state == nnPkg::drain);

	// the register block must refuse a start while a run is in flight
	noStartWhileBusy: assert property (
		@(posedge clk) disable iff (reset)
		start |-> !busy
	);

endmodule

`default_nettype wire

// ==== rtl/nnLayer.sv ====
`default_nettype none

module nnLayer (
	input wire logic clk,
	input wire logic reset,
	input nnPkg::apbReq apbIn,
	output nnPkg::apbRsp apbOut
);

	nnPkg::weightWrite weightWr;
	nnPkg::dotIssue issueTag;
	nnPkg::dotIssue readTag;
	nnPkg::neuronParams params;
	nnPkg::dotResult dotSum;
	nnPkg::activation result;
	logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] inputVector;
	logic start;
	logic busy;
	logic done;

	apbRegs regs (
		.clk(clk),
		.reset(reset),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.busy(busy),
		.done(done),
		.result(result),
		.weightWr(weightWr),
		.inputVector(inputVector),
		.start(start)
	);

	layerCtrl ctrl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.result(result),
		.issue(issueTag),
		.busy(busy),
		.done(done)
	);

	// ******************************
	// shared neuron pipeline
	// ******************************
	weightStore weights (
		.clk(clk),
		.reset(reset),
		.weightWr(weightWr),
		.issueIn(issueTag),
		.issueOut(readTag),
		.params(params)
	);

	neuronDot dot (
		.clk(clk),
		.reset(reset),
		.issueIn(readTag),
		.params(params),
		.inputVector(inputVector),
		.sum(dotSum)
	);

	reluQuant quant (
		.clk(clk),
		.reset(reset),
		.sum(dotSum),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
`default_nettype none

module tbClock (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset covers the first three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/tbNnLayer.sv ====
`default_nettype none

module tbNnLayer;

	localparam int cycleLimit = 20 * 200;

	logic clk;
	logic reset;
	nnPkg::apbReq apbIn;
	nnPkg::apbRsp apbOut;

	logic [31:0] lfsrState;
	int cycles;
	int valueErrors;
	int statusErrors;
	int protocolErrors;
	logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] inVec;
	logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] wts [nnPkg::neuronCount];
	logic [nnPkg::biasWidth-1:0] bias [nnPkg::neuronCount];

	tbClock clockGen (.clk(clk), .reset(reset));

	nnLayer dut (.clk(clk), .reset(reset), .apbIn(apbIn), .apbOut(apbOut));

	// x^32 + x^22 + x^2 + x + 1, one new bit per step
	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < width; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [nnPkg::dataWidth-1:0] expectedValue(
		input logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] x,
		input logic [nnPkg::neuronInputs-1:0][nnPkg::dataWidth-1:0] w,
		input logic [nnPkg::biasWidth-1:0] b
	);
		int total;
		total = int'($signed(b));
		for (int i = 0; i < nnPkg::neuronInputs; i++)
			total += int'($signed(x[i])) * int'($signed(w[i]));
		if (total < 0)
			return '0;
		if (total >= 8192)
			return 8'd127;
		// six fraction bits dropped, rounded half up
		return 8'((total >>> 6) + ((total >>> 5) & 1));
	endfunction

	function automatic logic [11:0] weightAddr(input int n, input int s);
		return nnPkg::weightBase + 12'(64 * n + 4 * s);
	endfunction

	function automatic logic [11:0] resultAddr(input int n);
		return nnPkg::resultBase + 12'(4 * n);
	endfunction

	// ******************************
	// APB access
	// ******************************
	task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		apbIn.paddr = addr;
		apbIn.pwrite = wr;
		apbIn.pwdata = wdata;
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		@(posedge clk);
		#2;
		apbIn.penable = 1'b1;
		@(negedge clk);
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		if (apbOut.pready !== 1'b1)
		begin
			protocolErrors++;
			$display("time %0t: pready was low in the access phase at 0x%03h", $time, addr);
		end
		@(posedge clk);
		#2;
		apbIn.psel = 1'b0;
		apbIn.penable = 1'b0;
	endtask

	task automatic writeReg(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apbXfer(1'b1, addr, data, rd, err);
		if (err)
		begin
			protocolErrors++;
			$display("time %0t: write to 0x%03h was refused with pslverr", $time, addr);
		end
	endtask

	task automatic readReg(input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apbXfer(1'b0, addr, '0, data, err);
		if (err)
		begin
			protocolErrors++;
			$display("time %0t: read of 0x%03h was refused with pslverr", $time, addr);
		end
	endtask

	task automatic expectSlvErr(input logic wr, input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apbXfer(wr, addr, data, rd, err);
		if (!err)
		begin
			protocolErrors++;
			$display("time %0t: access to 0x%03h should have raised pslverr but did not",
				$time, addr);
		end
		if (!wr && rd !== '0)
		begin
			protocolErrors++;
			$display("[FAIL] %0t read of unmapped 0x%03h: expected 0, got 0x%08h",
				$time, addr, rd);
		end
	endtask

	task automatic checkValue(input logic [nnPkg::dataWidth-1:0] expected,
		input logic [nnPkg::dataWidth-1:0] actual, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t %s: expected %0d, got %0d", $time, what, expected, actual);
		end
	endtask

	// status bits as {done, busy}
	task automatic checkStatus(input logic [1:0] expected, input logic [1:0] actual,
		input string what);
		if (actual !== expected)
		begin
			statusErrors++;
			$display("[FAIL] %0t %s: expected %b, got %b", $time, what, expected, actual);
		end
	endtask

	// ******************************
	// layer sequences
	// ******************************
	task automatic loadNeuron(input int n);
		for (int s = 0; s < nnPkg::neuronInputs; s++)
			writeReg(weightAddr(n, s), {24'h0, wts[n][s]});
		writeReg(weightAddr(n, 15), {16'h0, bias[n]});
	endtask

	task automatic loadInputs();
		for (int s = 0; s < nnPkg::neuronInputs; s++)
			writeReg(nnPkg::inputBase + 12'(4 * s), {24'h0, inVec[s]});
	endtask

	// illegal writes can be slipped in while the run is in flight
	task automatic runLayer(input logic poke);
		logic [31:0] rd;
		writeReg(nnPkg::ctrlAddr, 32'h1);
		readReg(nnPkg::statusAddr, rd);
		checkStatus(2'b01, rd[1:0], "status after start");
		if (poke)
		begin
			expectSlvErr(1'b1, weightAddr(0, 0), 32'h55);
			expectSlvErr(1'b1, nnPkg::inputBase, 32'h33);
			expectSlvErr(1'b1, nnPkg::ctrlAddr, 32'h1);
		end
		rd = '0;
		while (!rd[1])
			readReg(nnPkg::statusAddr, rd);
		checkStatus(2'b10, rd[1:0], "status at end of run");
		for (int n = 0; n < nnPkg::neuronCount; n++)
		begin
			readReg(resultAddr(n), rd);
			checkValue(expectedValue(inVec, wts[n], bias[n]), rd[7:0], "neuron result");
		end
	endtask

	task automatic checkFirst(input logic [nnPkg::dataWidth-1:0] expected);
		logic [31:0] rd;
		readReg(resultAddr(0), rd);
		checkValue(expected, rd[7:0], "directed neuron 0");
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] rd;
		logic [31:0] r;
		apbIn = '0;
		lfsrState = 32'h1641;
		cycles = 0;
		valueErrors = 0;
		statusErrors = 0;
		protocolErrors = 0;
		wait (!reset);
		@(posedge clk);
		#2;

		readReg(nnPkg::statusAddr, rd);
		checkStatus(2'b00, rd[1:0], "status after reset");
		for (int n = 0; n < nnPkg::neuronCount; n++)
		begin
			readReg(resultAddr(n), rd);
			checkValue('0, rd[7:0], "result after reset");
		end

		// ******************************
		// directed cases on neuron 0
		// ******************************
		wts[0] = {8'd10, -8'sd2, 8'd27, 8'd6, -8'sd11, 8'd21, 8'd15, -8'sd4, 8'd9, 8'd30,
			-8'sd18, 8'd3, 8'd25, -8'sd7, 8'd12};
		bias[0] = 16'hFE00;
		for (int n = 1; n < nnPkg::neuronCount; n++)
		begin
			wts[n] = '0;
			bias[n] = '0;
		end
		for (int n = 0; n < nnPkg::neuronCount; n++)
			loadNeuron(n);
		inVec = '0;
		loadInputs();
		runLayer(1'b0);
		checkFirst(8'd0);
		// all inputs at 127 give 116 * 127 - 512, far above saturation
		inVec = {15{8'd127}};
		loadInputs();
		runLayer(1'b1);
		checkFirst(8'd127);
		readReg(nnPkg::inputBase, rd);
		checkValue(8'd127, rd[7:0], "input 0 after refused write");
		// 51 * 12 - 512 = 100, so 1 plus a rounding bit
		inVec = '0;
		inVec[0] = 8'd51;
		loadInputs();
		runLayer(1'b0);
		checkFirst(8'd2);

		expectSlvErr(1'b0, 12'h008, '0);
		expectSlvErr(1'b1, 12'h3FC, 32'hFF);
		expectSlvErr(1'b1, nnPkg::inputBase + 12'h03C, 32'h11);
		checkFirst(8'd2);

		// ******************************
		// random runs
		// ******************************
		for (int run = 0; run < 16; run++)
		begin
			for (int n = 0; n < nnPkg::neuronCount; n++)
			begin
				for (int s = 0; s < nnPkg::neuronInputs; s++)
				begin
					r = randomBits(run[0] ? 5 : 8);
					wts[n][s] = run[0] ? {{3{r[4]}}, r[4:0]} : r[7:0];
				end
				r = randomBits(12);
				bias[n] = {{4{r[11]}}, r[11:0]};
				loadNeuron(n);
			end
			for (int s = 0; s < nnPkg::neuronInputs; s++)
			begin
				r = randomBits(8);
				inVec[s] = r[7:0];
			end
			loadInputs();
			runLayer(1'b0);
		end

		// the stored weights carry over to a run with new inputs only
		for (int s = 0; s < nnPkg::neuronInputs; s++)
		begin
			r = randomBits(8);
			inVec[s] = r[7:0];
		end
		loadInputs();
		runLayer(1'b0);

		$display("value errors: %0d, status errors: %0d, protocol errors: %0d",
			valueErrors, statusErrors, protocolErrors);
		if (valueErrors + statusErrors + protocolErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/nnPkg.sv
rtl/apbRegs.sv
rtl/weightStore.sv
rtl/neuronDot.sv
rtl/reluQuant.sv
rtl/layerCtrl.sv
rtl/nnLayer.sv
tests/tbClock.sv
tests/tbNnLayer.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tbNnLayer \
	-o simNnLayer \
	&& ./obj_dir/simNnLayer | tee /dev/stderr | grep -q "test passed" \
	|| exit 1
